// ==== project.f ====
source/analog_pkg.sv
source/adc_front_end.sv
source/dac_sum_sat.sv
source/moving_avg.sv
source/dac_output_stage.sv
source/analog_top.sv
tests/analog_checker.sv
tests/tb_analog_top.sv

// ==== Bender.yml ====
package:
  name: analog_top

sources:
  # Package first, then leaf blocks, then the top level
  - source/analog_pkg.sv
  - source/adc_front_end.sv
  - source/dac_sum_sat.sv
  - source/moving_avg.sv
  - source/dac_output_stage.sv
  - source/analog_top.sv

  # Testbench with its checker
  - target: test
    files:
      - tests/analog_checker.sv
      - tests/tb_analog_top.sv

// ==== tests/tb_analog_top.sv ====
// Testbench for the analog path with seeded random stimulus, test sequence and watchdog
`timescale 1ns/1ps

module tb_analog_top;

  import analog_pkg::*;

  localparam int CLK_NS         = 8;
  localparam int RST_CYCLES     = 8;
  localparam int ADC_CYCLES     = 400;
  localparam int SAT_CYCLES     = 400;
  localparam int LOOP_CYCLES    = 200;
  localparam int AVG_CYCLES     = 600;
  localparam int RESTART_CYCLES = 100;
  localparam int NUM_TESTS      = 5;
  // Initial reset, two restarts and one settling cycle per test
  localparam int TOTAL_CYCLES   = 3 * RST_CYCLES + ADC_CYCLES + SAT_CYCLES + LOOP_CYCLES
                                  + AVG_CYCLES + RESTART_CYCLES + NUM_TESTS;

  localparam int LOOP_OFF  = 0;
  localparam int LOOP_ON   = 1;
  localparam int LOOP_RAND = 2;

  localparam logic [SAMPLE_W-1:0] ZERO_CODE = 14'h1FFF;  // DAC code of 0

  logic         adc_clk;
  logic         adc_rstn;
  raw_pair_t    adc_dat_i;
  sample_pair_t asg_dat_i;
  sample_pair_t pid_dat_i;
  logic         loopback_i;
  sample_pair_t adc_dat_o;
  code_pair_t   dac_code_o;

  int     err_cnt;     // From the checker
  int     chk_cnt;
  int     bench_errs;  // Reset value checks done here
  int     tests_pass;
  int     tests_fail;
  integer seed;

  analog_top dut (
    .adc_clk    (adc_clk   ),
    .adc_rstn   (adc_rstn  ),
    .adc_dat_i  (adc_dat_i ),
    .asg_dat_i  (asg_dat_i ),
    .pid_dat_i  (pid_dat_i ),
    .loopback_i (loopback_i),
    .adc_dat_o  (adc_dat_o ),
    .dac_code_o (dac_code_o)
  );

  analog_checker i_checker (
    .adc_clk    (adc_clk   ),
    .adc_rstn   (adc_rstn  ),
    .adc_raw_i  (adc_dat_i ),
    .asg_i      (asg_dat_i ),
    .pid_i      (pid_dat_i ),
    .loopback_i (loopback_i),
    .adc_smp_i  (adc_dat_o ),
    .dac_code_i (dac_code_o),
    .err_cnt_o  (err_cnt   ),
    .chk_cnt_o  (chk_cnt   )
  );

  initial adc_clk = 1'b0;
  always #(CLK_NS / 2) adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Half of the big samples sit within 63 LSB of a rail
  function automatic sample_t pick_sample(bit big);
    int      r;
    sample_t res;
    r   = $random(seed);
    res = sample_t'(r);
    if (big && r[31]) begin
      if (r[30]) res = sample_t'(SAMPLE_MAX - int'(r[5:0]));
      else       res = sample_t'(SAMPLE_MIN + int'(r[5:0]));
    end
    return res;
  endfunction

  task automatic run_cycles(input int cycles, input bit big, input int loop_mode);
    int r;
    repeat (cycles) begin
      @(posedge adc_clk);
      #1;
      adc_dat_i.a = 16'($random(seed));
      adc_dat_i.b = 16'($random(seed));
      asg_dat_i.a = pick_sample(big);
      asg_dat_i.b = pick_sample(big);
      pid_dat_i.a = pick_sample(big);
      pid_dat_i.b = pick_sample(big);
      r = $random(seed);
      if (loop_mode == LOOP_RAND) loopback_i = r[0];
      else                        loopback_i = (loop_mode == LOOP_ON);
    end
  endtask

  // Both codes must sit at midscale while reset is held
  task automatic expect_idle_codes();
    if (dac_code_o.a !== ZERO_CODE || dac_code_o.b !== ZERO_CODE) begin
      bench_errs++;
      $display("mismatch at %0t ns: DAC codes in reset got a %h b %h expected %h",
               $time, dac_code_o.a, dac_code_o.b, ZERO_CODE);
    end
  endtask

  task automatic apply_reset(input bit check_idle);
    @(posedge adc_clk);
    #1;
    adc_rstn = 1'b0;
    repeat (RST_CYCLES) begin
      @(posedge adc_clk);
      #1;
      if (check_idle) expect_idle_codes();
    end
    adc_rstn = 1'b1;  // Released after exactly 8 edges
  endtask

  task automatic finish_test(input int num, input string name, input int base);
    int errs;
    @(negedge adc_clk);  // Let the last cycle be compared
    #1;
    errs = err_cnt + bench_errs - base;
    if (errs == 0) begin
      tests_pass++;
      $display("test %0d %s: PASS", num, name);
    end else begin
      tests_fail++;
      $display("test %0d %s: FAIL with %0d mismatches", num, name, errs);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int base;
    seed       = 32'h2718;
    adc_rstn   = 1'b0;
    adc_dat_i  = '0;
    asg_dat_i  = '0;
    pid_dat_i  = '0;
    loopback_i = 1'b0;
    bench_errs = 0;
    tests_pass = 0;
    tests_fail = 0;

    repeat (RST_CYCLES) @(posedge adc_clk);
    #1;
    adc_rstn = 1'b1;

    base = err_cnt + bench_errs;
    run_cycles(ADC_CYCLES, 1'b0, LOOP_OFF);
    finish_test(1, "adc conversion", base);

    base = err_cnt + bench_errs;
    run_cycles(SAT_CYCLES, 1'b1, LOOP_OFF);
    finish_test(2, "channel B saturation", base);

    base = err_cnt + bench_errs;
    run_cycles(LOOP_CYCLES, 1'b0, LOOP_ON);
    finish_test(3, "digital loopback", base);

    // Fresh reset so the window starts from zeros
    base = err_cnt + bench_errs;
    apply_reset(1'b0);
    run_cycles(AVG_CYCLES / 2, 1'b0, LOOP_OFF);
    run_cycles(AVG_CYCLES / 2, 1'b1, LOOP_OFF);  // Rail heavy samples push the average
    finish_test(4, "moving average", base);

    base = err_cnt + bench_errs;
    apply_reset(1'b1);
    run_cycles(RESTART_CYCLES, 1'b1, LOOP_RAND);
    finish_test(5, "reset mid-run", base);

    $display("summary: %0d tests pass, %0d tests fail, %0d checks, %0d mismatches",
             tests_pass, tests_fail, chk_cnt, err_cnt + bench_errs);
    if (chk_cnt == 0) $display("the checker made no comparisons during the run");
    if (tests_fail == 0 && err_cnt == 0 && bench_errs == 0 && chk_cnt > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog at twice the expected run length
  initial begin
    #(2 * TOTAL_CYCLES * CLK_NS);
    $display("watchdog: the run timed out after %0d ns", 2 * TOTAL_CYCLES * CLK_NS);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== tests/analog_checker.sv ====
// Reference model of the analog path that compares DUT outputs every cycle and counts mismatches
`timescale 1ns/1ps

module analog_checker (
  input  logic                     adc_clk,     // ADC sample clock
  input  logic                     adc_rstn,    // Sync reset, active low
  input  analog_pkg::raw_pair_t    adc_raw_i,   // Raw words seen by the DUT
  input  analog_pkg::sample_pair_t asg_i,       // Generator samples
  input  analog_pkg::sample_pair_t pid_i,       // Controller samples
  input  logic                     loopback_i,  // Loopback select
  input  analog_pkg::sample_pair_t adc_smp_i,   // DUT converted samples
  input  analog_pkg::code_pair_t   dac_code_i,  // DUT DAC codes
  output int                       err_cnt_o,   // Mismatches so far
  output int                       chk_cnt_o    // Comparisons so far
);

  import analog_pkg::*;

  // Every bit but the top one flips in the converter mapping
  localparam logic [SAMPLE_W-1:0] LOW_MASK = {1'b0, {(SAMPLE_W-1){1'b1}}};

  logic [SAMPLE_W-1:0] raw_a_m;           // Model raw register A
  logic [SAMPLE_W-1:0] raw_b_m;           // Model raw register B
  int                  ring_m [AVG_DEPTH];
  int                  idx_m;
  int                  sum_m;             // Exact window sum
  logic [SAMPLE_W-1:0] code_a_m;          // Expected registered codes
  logic [SAMPLE_W-1:0] code_b_m;
  bit                  model_ok;          // Set once reset has been seen

  ////////////////////////////////////////////////////////////////////////////
  // Model rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic int from_code(logic [SAMPLE_W-1:0] c);
    sample_t s;
    s = sample_t'(c ^ LOW_MASK);
    return int'(s);
  endfunction

  function automatic int clamp_sum(int x, int y);
    int s;
    s = x + y;
    if (s > SAMPLE_MAX) s = SAMPLE_MAX;
    if (s < SAMPLE_MIN) s = SAMPLE_MIN;
    return s;
  endfunction

  // Round toward minus infinity, also for negative sums
  function automatic int floor_avg(int s);
    if (s >= 0) return s / AVG_DEPTH;
    return -((-s + AVG_DEPTH - 1) / AVG_DEPTH);
  endfunction

  function automatic logic [SAMPLE_W-1:0] code_of(int v);
    logic [SAMPLE_W-1:0] bits;
    bits = SAMPLE_W'(v);
    return bits ^ LOW_MASK;
  endfunction

  task automatic check_word(input string what, input logic [SAMPLE_W-1:0] got,
                            input logic [SAMPLE_W-1:0] exp);
    chk_cnt_o++;
    if (got !== exp) begin
      err_cnt_o++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
    model_ok  = 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model state, advanced at the same edge as the DUT
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk) begin
    int new_a;
    if (!adc_rstn) begin
      raw_a_m = '0;
      raw_b_m = '0;
      for (int i = 0; i < AVG_DEPTH; i++) ring_m[i] = 0;  // Zero window
      idx_m    = 0;
      sum_m    = 0;
      code_a_m = code_of(0);
      code_b_m = code_of(0);
      model_ok = 1'b1;
    end else begin
      raw_a_m  = adc_raw_i.a[ADC_IN_W-1 -: SAMPLE_W];  // Upper 14 bits
      raw_b_m  = adc_raw_i.b[ADC_IN_W-1 -: SAMPLE_W];
      code_a_m = code_of(floor_avg(sum_m));            // Window before this edge
      code_b_m = code_of(clamp_sum(asg_i.b, pid_i.b));
      new_a    = clamp_sum(asg_i.a, pid_i.a);
      sum_m    = sum_m + new_a - ring_m[idx_m];
      ring_m[idx_m] = new_a;
      idx_m    = (idx_m + 1) % AVG_DEPTH;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare mid cycle, inputs and registers both settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge adc_clk) begin
    int exp_a;
    int exp_b;
    if (model_ok) begin
      if (loopback_i) begin
        exp_a = clamp_sum(asg_i.a, pid_i.a);  // Same cycle sums
        exp_b = clamp_sum(asg_i.b, pid_i.b);
      end else begin
        exp_a = from_code(raw_a_m);
        exp_b = from_code(raw_b_m);
      end
      check_word("adc_dat_o.a", adc_smp_i.a, SAMPLE_W'(exp_a));
      check_word("adc_dat_o.b", adc_smp_i.b, SAMPLE_W'(exp_b));
      check_word("dac_code_o.a", dac_code_i.a, code_a_m);
      check_word("dac_code_o.b", dac_code_i.b, code_b_m);
    end
  end

endmodule

// ==== source/analog_top.sv ====
// Analog data path top wiring ADC capture, DAC summing, channel A averaging and DAC codes
`timescale 1ns/1ps

module analog_top (
  input  logic                     adc_clk,     // Single clock for the whole path
  input  logic                     adc_rstn,    // Sync reset, active low
  input  analog_pkg::raw_pair_t    adc_dat_i,   // Raw ADC words
  input  analog_pkg::sample_pair_t asg_dat_i,   // Generator samples
  input  analog_pkg::sample_pair_t pid_dat_i,   // Controller samples
  input  logic                     loopback_i,  // Digital loopback
  output analog_pkg::sample_pair_t adc_dat_o,   // Converted ADC samples
  output analog_pkg::code_pair_t   dac_code_o   // DAC codes for A and B
);

  import analog_pkg::*;

  sample_pair_t sat;      // Clamped generator plus controller
  sample_t      avg_a;    // Channel A window average
  sample_pair_t dac_smp;  // What goes to the output stage

  ////////////////////////////////////////////////////////////////////////////
  // ADC side
  ////////////////////////////////////////////////////////////////////////////

  adc_front_end i_adc_front_end (
    .adc_clk    (adc_clk   ),
    .adc_rstn   (adc_rstn  ),
    .adc_raw_i  (adc_dat_i ),
    .loop_smp_i (sat       ),  // Loopback source
    .loopback_i (loopback_i),
    .adc_smp_o  (adc_dat_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // DAC side
  ////////////////////////////////////////////////////////////////////////////

  dac_sum_sat i_dac_sum_sat (
    .adc_clk  (adc_clk  ),
    .adc_rstn (adc_rstn ),
    .asg_i    (asg_dat_i),
    .pid_i    (pid_dat_i),
    .sat_o    (sat      )
  );

  // Only channel A is averaged
  moving_avg i_moving_avg (
    .adc_clk  (adc_clk ),
    .adc_rstn (adc_rstn),
    .smp_i    (sat.a   ),
    .avg_o    (avg_a   )
  );

  // B goes straight from the summer
  assign dac_smp = '{a: avg_a, b: sat.b};

  dac_output_stage i_dac_output_stage (
    .adc_clk    (adc_clk   ),
    .adc_rstn   (adc_rstn  ),
    .dac_smp_i  (dac_smp   ),
    .dac_code_o (dac_code_o)
  );

endmodule

// ==== source/dac_output_stage.sv ====
// DAC output stage that turns signed samples into negative slope codes and registers them
`timescale 1ns/1ps

module dac_output_stage (
  input  logic                     adc_clk,     // ADC sample clock
  input  logic                     adc_rstn,    // Sync reset, active low
  input  analog_pkg::sample_pair_t dac_smp_i,   // Averaged A and saturated B
  output analog_pkg::code_pair_t   dac_code_o   // Registered converter codes
);

  import analog_pkg::*;

  // Two's complement to the converter's offset code
  // Keep bit 13 and invert the lower bits
  function automatic dac_code_t to_code(sample_t smp);
    dac_code_t code;
    code = {smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]};
    return code;
  endfunction

  code_pair_t code_nxt;  // Unregistered codes

  ////////////////////////////////////////////////////////////////////////////
  // Code mapping
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    code_nxt.a = to_code(dac_smp_i.a);
    code_nxt.b = to_code(dac_smp_i.b);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // Reset parks both outputs at midscale
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_code_o.a <= to_code('0);  // 0x1FFF
      dac_code_o.b <= to_code('0);
    end else begin
      dac_code_o <= code_nxt;
    end
  end

endmodule

// ==== source/moving_avg.sv ====
// Running average of the last 64 channel A samples using a ring buffer and a running sum
`timescale 1ns/1ps

module moving_avg (
  input  logic                adc_clk,   // ADC sample clock
  input  logic                adc_rstn,  // Sync reset, active low
  input  analog_pkg::sample_t smp_i,     // Saturated channel A sample
  output analog_pkg::sample_t avg_o      // Floor average of the window
);

  import analog_pkg::*;

  sample_t                     ring_q [AVG_DEPTH];  // Past samples
  logic    [AVG_SHIFT-1:0]     idx_q;               // Next slot to overwrite
  logic signed [AVG_SUM_W-1:0] sum_q;               // Sum of all ring entries
  logic signed [AVG_SUM_W-1:0] new_ext;             // Incoming sample widened
  logic signed [AVG_SUM_W-1:0] old_ext;             // Retiring sample widened
  logic signed [AVG_SUM_W-1:0] sum_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Sum update
  ////////////////////////////////////////////////////////////////////////////

  // Sign extend both operands to the accumulator width
  always_comb begin
    new_ext = {{(AVG_SUM_W - SAMPLE_W){smp_i[SAMPLE_W-1]}}, smp_i};
    old_ext = {{(AVG_SUM_W - SAMPLE_W){ring_q[idx_q][SAMPLE_W-1]}}, ring_q[idx_q]};
    sum_nxt = sum_q + new_ext - old_ext;  // Add new, drop oldest
  end

  ////////////////////////////////////////////////////////////////////////////
  // Ring buffer and accumulator
  ////////////////////////////////////////////////////////////////////////////

  // Ring must be zero after reset
  // so the window restarts from an all zero history
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      for (int i = 0; i < AVG_DEPTH; i++) begin
        ring_q[i] <= '0;
      end
      idx_q <= '0;
      sum_q <= '0;
    end else begin
      ring_q[idx_q] <= smp_i;            // Overwrite oldest
      idx_q         <= idx_q + 1'b1;     // Wraps at 64 on its own
      sum_q         <= sum_nxt;
    end
  end

  // Divide by 64
  // arithmetic shift keeps the floor for negative sums
  assign avg_o = sample_t'(sum_q >>> AVG_SHIFT);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Index walks the ring one slot per cycle and stays inside it
  a_idx_step: assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
      $past(adc_rstn) |->
        (32'(idx_q) < AVG_DEPTH) && (idx_q == AVG_SHIFT'($past(idx_q) + 1'b1))
  ) else $error("moving_avg: write index skipped a slot");

  // Accumulator never drifts past 64 full scale samples
  a_sum_range: assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
      (sum_q >= AVG_DEPTH * SAMPLE_MIN) && (sum_q <= AVG_DEPTH * SAMPLE_MAX)
  ) else $error("moving_avg: running sum out of range");

endmodule

// ==== source/dac_sum_sat.sv ====
// DAC summer that adds generator and controller samples per channel and clamps to 14 bits
`timescale 1ns/1ps

module dac_sum_sat (
  input  logic                     adc_clk,   // Only for checking
  input  logic                     adc_rstn,  // Sync reset, active low
  input  analog_pkg::sample_pair_t asg_i,     // Generator samples
  input  analog_pkg::sample_pair_t pid_i,     // Controller samples
  output analog_pkg::sample_pair_t sat_o      // Clamped sums
);

  import analog_pkg::*;

  // Widen, add and clamp one channel
  function automatic sample_t sat_add(sample_t x, sample_t y);
    logic signed [SUM_W-1:0] sum;
    sample_t                 res;
    sum = $signed({x[SAMPLE_W-1], x}) + $signed({y[SAMPLE_W-1], y});
    if (sum > SAMPLE_MAX) begin
      res = sample_t'(SAMPLE_MAX);  // Positive rail
    end else if (sum < SAMPLE_MIN) begin
      res = sample_t'(SAMPLE_MIN);  // Negative rail
    end else begin
      res = sample_t'(sum);         // In range, pass through
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Summing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sat_o.a = sat_add(asg_i.a, pid_i.a);
    sat_o.b = sat_add(asg_i.b, pid_i.b);
  end

  // In range and never wrapped
  // Two inputs of equal sign must give a result of that sign
  property p_clamp(sample_t x, sample_t y, sample_t s);
    @(posedge adc_clk) disable iff (!adc_rstn)
      (s >= SAMPLE_MIN) && (s <= SAMPLE_MAX) &&
      ((x[SAMPLE_W-1] == y[SAMPLE_W-1]) -> (s[SAMPLE_W-1] == x[SAMPLE_W-1]));
  endproperty

  a_clamp_a: assert property (p_clamp(asg_i.a, pid_i.a, sat_o.a))
    else $error("dac_sum_sat: channel A sum wrapped");
  a_clamp_b: assert property (p_clamp(asg_i.b, pid_i.b, sat_o.b))
    else $error("dac_sum_sat: channel B sum wrapped");

endmodule

// ==== source/adc_front_end.sv ====
// ADC front end that registers raw words, converts them to signed samples and muxes loopback
`timescale 1ns/1ps

module adc_front_end (
  input  logic                     adc_clk,     // ADC sample clock
  input  logic                     adc_rstn,    // Sync reset, active low
  input  analog_pkg::raw_pair_t    adc_raw_i,   // Raw words from converter pins
  input  analog_pkg::sample_pair_t loop_smp_i,  // Saturated DAC side samples
  input  logic                     loopback_i,  // Digital loopback select
  output analog_pkg::sample_pair_t adc_smp_o    // Signed samples to the fabric
);

  import analog_pkg::*;

  logic [SAMPLE_W-1:0] raw_a_q;  // Channel A code from last edge
  logic [SAMPLE_W-1:0] raw_b_q;  // Channel B code from last edge
  sample_pair_t        conv;     // Converted register contents

  ////////////////////////////////////////////////////////////////////////////
  // Input register
  ////////////////////////////////////////////////////////////////////////////

  // Lowest two bits are reserved for 16 bit converters
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_raw_i.a[ADC_IN_W-1 -: SAMPLE_W];  // Keep bits 15..2
      raw_b_q <= adc_raw_i.b[ADC_IN_W-1 -: SAMPLE_W];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Conversion and loopback
  ////////////////////////////////////////////////////////////////////////////

  // Negative slope code to two's complement
  // Top bit stays, the rest flips
  always_comb begin
    conv.a = sample_t'({raw_a_q[SAMPLE_W-1], ~raw_a_q[SAMPLE_W-2:0]});
    conv.b = sample_t'({raw_b_q[SAMPLE_W-1], ~raw_b_q[SAMPLE_W-2:0]});
  end

  // Loopback bypasses the register entirely
  always_comb begin
    if (loopback_i) begin
      adc_smp_o = loop_smp_i;  // Same cycle DAC samples
    end else begin
      adc_smp_o = conv;
    end
  end

  // Whichever source is selected must be clean once out of reset
  a_smp_known: assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
      !$isunknown(adc_smp_o)
  ) else $error("adc_front_end: unknown bits on sample output");

endmodule

// ==== source/analog_pkg.sv ====
// Analog path package with sample widths, averaging depth and packed channel pair types

package analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADC_IN_W  = 16;  // Raw ADC word incl. two reserved LSBs
  localparam int SAMPLE_W  = 14;  // Processed sample and DAC code
  localparam int SUM_W     = 15;  // Generator plus controller before clamping

  ////////////////////////////////////////////////////////////////////////////
  // Moving average
  ////////////////////////////////////////////////////////////////////////////

  localparam int AVG_DEPTH = 64;  // Window length in samples
  localparam int AVG_SHIFT = 6;   // log2 of window
  localparam int AVG_SUM_W = 20;  // Holds 64 full scale samples

  // Signed 14 bit limits
  localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
  localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [SAMPLE_W-1:0] sample_t;    // Two's complement sample
  typedef logic        [SAMPLE_W-1:0] dac_code_t;  // Neg slope offset code

  // Raw converter words of both channels
  typedef struct packed {
    logic [ADC_IN_W-1:0] a;
    logic [ADC_IN_W-1:0] b;
  } raw_pair_t;

  // Signed samples of both channels
  typedef struct packed {
    sample_t a;
    sample_t b;
  } sample_pair_t;

  // Output codes of both channels
  typedef struct packed {
    dac_code_t a;
    dac_code_t b;
  } code_pair_t;

endpackage
